/* all.f */
+incdir+common
common/cpu_isa_pkg.sv
common/hazard_pkg.sv
hazard/dest_tracker.sv
hazard/stall_detector.sv
hazard/forward_selector.sv
hazard/hazard_combiner.sv
hdl/hazard_top.sv
sim/tb_clock_gen.sv
sim/hazard_checker.sv
sim/hazard_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the hazard subsystem testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module hazard_tb -f all.f -o hazard_sim
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

./obj_dir/hazard_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

# the log decides the verdict
if grep -q "^TEST RESULT: PASS$" sim.log; then
   echo "simulation passed"
   exit 0
fi

echo "pass message not found in sim.log"
exit 1

/* sim/hazard_tb.sv */
`timescale 1ns/1ps

module hazard_tb
   import cpu_isa_pkg::*, hazard_pkg::*;
();

   logic        clk;
   logic        rst_n;
   logic        id_valid;
   id_instr_t   id_instr;
   logic        pc_we;
   logic        if_id_we;
   logic        id_ex_bubble;
   fw_sel_t     fw_a_sel;
   fw_sel_t     fw_b_sel;

   stage_info_t model [3]; // 0 = ID/EX, 1 = EX/MEM, 2 = MEM/WB
   int          errors;
   int          checks;
   int          seed;
   logic        obs_stall; // last stall seen on the DUT
   fw_sel_t     obs_a;
   fw_sel_t     obs_b;
   id_instr_t   nop;

   tb_clock_gen u_clk (.o_clk(clk));

   hazard_top dut (
      .i_clk          (clk),
      .i_rst_n        (rst_n),
      .i_id_valid     (id_valid),
      .i_id_instr     (id_instr),
      .o_pc_we        (pc_we),
      .o_if_id_we     (if_id_we),
      .o_id_ex_bubble (id_ex_bubble),
      .o_fw_a_sel     (fw_a_sel),
      .o_fw_b_sel     (fw_b_sel)
   );

   bind hazard_top hazard_checker u_checker (
      .i_clk          (i_clk),
      .i_rst_n        (i_rst_n),
      .i_pc_we        (o_pc_we),
      .i_if_id_we     (o_if_id_we),
      .i_id_ex_bubble (o_id_ex_bubble),
      .i_fw_a_sel     (o_fw_a_sel),
      .i_fw_b_sel     (o_fw_b_sel)
   );

   function automatic id_instr_t make_instr(input int rs, input int rt, input int rd,
                                            input logic wfr, input logic ld,
                                            input logic br, input logic jr);
      id_instr_t ins;
      ins.rs       = reg_idx_t'(rs);
      ins.rt       = reg_idx_t'(rt);
      ins.rd       = reg_idx_t'(rd);
      ins.wfr      = wfr;
      ins.read_mem = ld;
      ins.branch   = br;
      ins.jump     = jr;
      return ins;
   endfunction

   // stage owes register r and r0 never counts
   function automatic logic stage_hits(input stage_info_t s, input reg_idx_t r);
      return s.valid && s.wfr && (s.rd != '0) && (s.rd == r);
   endfunction

   function automatic logic expect_stall(input logic v, input id_instr_t ins);
      logic rs_busy;
      logic rt_busy;
      logic load_use;
      rs_busy = 1'b0;
      rt_busy = 1'b0;
      for (int i = 0; i < 3; i++) begin
         rs_busy = rs_busy | stage_hits(model[i], ins.rs);
         rt_busy = rt_busy | stage_hits(model[i], ins.rt);
      end
      load_use = model[0].read_mem &&
                 (stage_hits(model[0], ins.rs) || stage_hits(model[0], ins.rt));
      return v && (load_use || (ins.branch && (rs_busy || rt_busy)) || (ins.jump && rs_busy));
   endfunction

   // youngest producer first
   function automatic fw_sel_t pick_sel(input reg_idx_t r);
      if (stage_hits(model[1], r))
         return FW_EX_MEM;
      else if (stage_hits(model[2], r))
         return FW_MEM_WB;
      return FW_REGFILE;
   endfunction

   task automatic check_val(input string name, input int got, input int exp);
      checks++;
      assert (got == exp) else begin
         errors++;
         $display("ERR t=%0t %s got %0d exp %0d", $time, name, got, exp);
      end
   endtask

   task automatic shift_model(input logic take, input id_instr_t ins);
      model[2]          = model[1];
      model[1]          = model[0];
      model[0].valid    = take; // bubble or idle leaves an empty slot
      model[0].rs       = ins.rs;
      model[0].rt       = ins.rt;
      model[0].rd       = ins.rd;
      model[0].wfr      = ins.wfr;
      model[0].read_mem = ins.read_mem;
   endtask

   // runs from 1 ns after one edge to 1 ns after the next
   task automatic run_cycle(input logic v, input id_instr_t ins);
      logic    exp_stall;
      fw_sel_t exp_a;
      fw_sel_t exp_b;
      id_valid = v;
      id_instr = ins;
      #2; // outputs settled 1 ns before the edge
      exp_stall = expect_stall(v, ins);
      exp_a     = pick_sel(model[0].rs);
      exp_b     = pick_sel(model[0].rt);
      check_val("o_pc_we", int'(pc_we), int'(!exp_stall));
      check_val("o_if_id_we", int'(if_id_we), int'(!exp_stall));
      check_val("o_id_ex_bubble", int'(id_ex_bubble), int'(exp_stall));
      check_val("o_fw_a_sel", int'(fw_a_sel), int'(exp_a));
      check_val("o_fw_b_sel", int'(fw_b_sel), int'(exp_b));
      obs_stall = !if_id_we;
      obs_a     = fw_a_sel;
      obs_b     = fw_b_sel;
      @(posedge clk);
      shift_model(v && !exp_stall, ins);
      #1;
   endtask

   // hold the instruction in ID until the DUT lets it go
   task automatic issue(input id_instr_t ins, output int stalls);
      stalls = 0;
      run_cycle(1'b1, ins);
      while (obs_stall && stalls < 8) begin
         stalls++;
         run_cycle(1'b1, ins);
      end
      if (obs_stall) begin
         $display("timeout: ID stall did not clear within 8 cycles at t=%0t", $time);
         $display("TEST RESULT: FAIL");
         $finish;
      end
   endtask

   task automatic drain();
      repeat (3) run_cycle(1'b0, nop); // empty all three latches
   endtask

   task automatic report_test(input string name, input int err_before);
      $display("test %s done, errors=%0d", name, errors - err_before);
   endtask

   task automatic check_reset_state();
      int e0;
      e0 = errors;
      run_cycle(1'b0, nop);
      check_val("reset o_pc_we", int'(pc_we), 1);
      check_val("reset o_if_id_we", int'(if_id_we), 1);
      check_val("reset o_id_ex_bubble", int'(id_ex_bubble), 0);
      check_val("reset o_fw_a_sel", int'(obs_a), int'(FW_REGFILE));
      check_val("reset o_fw_b_sel", int'(obs_b), int'(FW_REGFILE));
      report_test("reset_state", e0);
   endtask

   task automatic load_use_case();
      int e0;
      int st;
      e0 = errors;
      issue(make_instr(1, 0, 5, 1, 1, 0, 0), st); // lw r5
      issue(make_instr(5, 6, 20, 1, 0, 0, 0), st); // reads r5 right behind
      check_val("load-use stall cycles", st, 1);
      run_cycle(1'b0, nop); // reader in EX with the load in MEM/WB
      check_val("load-use o_fw_a_sel", int'(obs_a), int'(FW_MEM_WB));
      drain();
      report_test("load_use", e0);
   endtask

   task automatic branch_case();
      int e0;
      int st;
      e0 = errors;
      issue(make_instr(1, 2, 7, 1, 0, 0, 0), st);
      issue(make_instr(7, 2, 0, 0, 0, 1, 0), st); // beq on rs
      check_val("branch rs stall cycles", st, 3); // writer crosses all three latches
      drain();
      issue(make_instr(1, 2, 8, 1, 0, 0, 0), st);
      issue(make_instr(1, 8, 0, 0, 0, 1, 0), st); // beq on rt
      check_val("branch rt stall cycles", st, 3);
      drain();
      issue(make_instr(1, 2, 0, 1, 0, 0, 0), st); // writes r0
      issue(make_instr(0, 0, 0, 0, 0, 1, 0), st);
      check_val("branch r0 stall cycles", st, 0);
      drain();
      report_test("branch", e0);
   endtask

   task automatic jump_case();
      int e0;
      int st;
      e0 = errors;
      issue(make_instr(1, 2, 9, 1, 0, 0, 0), st);
      issue(make_instr(9, 0, 0, 0, 0, 0, 1), st); // jr r9
      check_val("jump rs stall cycles", st, 3);
      drain();
      issue(make_instr(1, 2, 10, 1, 0, 0, 0), st);
      issue(make_instr(1, 10, 0, 0, 0, 0, 1), st); // rt is not read by jr
      check_val("jump rt-only stall cycles", st, 0);
      drain();
      report_test("jump", e0);
   endtask

   task automatic forward_priority();
      int e0;
      int st;
      e0 = errors;
      issue(make_instr(1, 2, 12, 1, 0, 0, 0), st);
      issue(make_instr(3, 4, 12, 1, 0, 0, 0), st); // newer value of r12
      issue(make_instr(12, 3, 21, 1, 0, 0, 0), st);
      run_cycle(1'b0, nop);
      check_val("priority o_fw_a_sel", int'(obs_a), int'(FW_EX_MEM));
      drain();
      issue(make_instr(1, 2, 13, 1, 0, 0, 0), st);
      issue(make_instr(3, 4, 13, 1, 0, 0, 0), st);
      issue(make_instr(2, 13, 22, 1, 0, 0, 0), st);
      run_cycle(1'b0, nop);
      check_val("priority o_fw_b_sel", int'(obs_b), int'(FW_EX_MEM));
      drain();
      report_test("forward_priority", e0);
   endtask

   task automatic random_stream();
      int        e0;
      int        st;
      int        kind;
      int        total_st;
      id_instr_t ins;
      e0       = errors;
      total_st = 0;
      for (int n = 0; n < 200; n++) begin
         kind = {$random(seed)} % 8;
         ins  = make_instr({$random(seed)} % 8, {$random(seed)} % 8, // small register set
                           {$random(seed)} % 8, 1'b1, 1'b0, 1'b0, 1'b0);
         if (kind < 2) begin
            ins.read_mem = 1'b1; // load
         end else if (kind == 2) begin
            ins.wfr    = 1'b0;
            ins.branch = 1'b1;
         end else if (kind == 3) begin
            ins.wfr  = 1'b0;
            ins.jump = 1'b1;
         end else if (kind == 7) begin
            ins.wfr = 1'b0; // store-like with no write
         end
         if ({$random(seed)} % 10 == 0)
            run_cycle(1'b0, nop); // idle slot in the stream
         issue(ins, st);
         total_st += st;
      end
      drain();
      $display("test random_stream done, 200 instructions, %0d stall cycles, errors=%0d",
               total_st, errors - e0);
   endtask

   // last-resort limit on the whole run
   initial begin
      #100000;
      $display("timeout: simulation did not reach the end of the tests");
      $display("TEST RESULT: FAIL");
      $finish;
   end

   initial begin
      seed     = 76;
      errors   = 0;
      checks   = 0;
      nop      = make_instr(0, 0, 0, 1'b0, 1'b0, 1'b0, 1'b0);
      rst_n    = 1'b0;
      id_valid = 1'b0;
      id_instr = nop;
      for (int i = 0; i < 3; i++)
         model[i] = '0;
      repeat (16) @(posedge clk); // reset held 16 cycles
      #1;
      rst_n = 1'b1;
      check_reset_state();
      load_use_case();
      branch_case();
      jump_case();
      forward_priority();
      random_stream();
      $display("all tests done: %0d checks, %0d errors", checks, errors);
      if (errors == 0) begin
         $display("TEST RESULT: PASS");
      end else begin
         $display("TEST RESULT: FAIL");
      end
      $finish;
   end

endmodule

/* sim/hazard_checker.sv */
`timescale 1ns/1ps

module hazard_checker
   import hazard_pkg::*;
(
   input logic    i_clk,
   input logic    i_rst_n,        // sync, active low
   input logic    i_pc_we,        // top-level o_pc_we
   input logic    i_if_id_we,     // top-level o_if_id_we
   input logic    i_id_ex_bubble, // top-level o_id_ex_bubble
   input fw_sel_t i_fw_a_sel,     // top-level o_fw_a_sel
   input fw_sel_t i_fw_b_sel      // top-level o_fw_b_sel
);

   // PC and IF/ID always freeze together
   a_we_pair: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      i_pc_we == i_if_id_we)
      else $error("pc and if/id write enables differ");

   // bubble only when the front end holds
   a_bubble_inv: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      i_id_ex_bubble == ~i_pc_we)
      else $error("bubble is not the inverse of the pc write enable");

   // code 3 is unused by the operand mux
   a_sel_a_code: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      i_fw_a_sel != fw_sel_t'(3))
      else $error("operand a select took the unused code");

   a_sel_b_code: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      i_fw_b_sel != fw_sel_t'(3))
      else $error("operand b select took the unused code");

endmodule

/* sim/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen (
   output logic o_clk // free-running testbench clock
);

   // 4 ns period, first rising edge at 2 ns
   initial begin
      o_clk = 1'b0;
   end

   always #2 o_clk = ~o_clk; // half period

endmodule

/* hdl/hazard_top.sv */
`timescale 1ns/1ps

module hazard_top
   import cpu_isa_pkg::*, hazard_pkg::*;
(
   input  logic      i_clk,
   input  logic      i_rst_n,        // sync, active low
   input  logic      i_id_valid,     // per-cycle issue strobe
   input  id_instr_t i_id_instr,     // held while o_if_id_we is low
   output logic      o_pc_we,
   output logic      o_if_id_we,
   output logic      o_id_ex_bubble,
   output fw_sel_t   o_fw_a_sel,
   output fw_sel_t   o_fw_b_sel
);

   pipe_state_t pipe;   // shadow latch record
   logic        stall;  // ID must wait
   fw_match_t   match;  // EX operand matches

   dest_tracker u_dest_tracker (
      .i_clk      (i_clk),
      .i_rst_n    (i_rst_n),
      .i_id_valid (i_id_valid),
      .i_id_instr (i_id_instr),
      .i_bubble   (o_id_ex_bubble), // fed back from combiner
      .o_pipe     (pipe)
   );

   stall_detector u_stall_detector (
      .i_id_valid (i_id_valid),
      .i_id_instr (i_id_instr),
      .i_pipe     (pipe),
      .o_stall    (stall)
   );

   forward_selector u_forward_selector (
      .i_pipe  (pipe),
      .o_match (match)
   );

   hazard_combiner u_hazard_combiner (
      .i_stall        (stall),
      .i_match        (match),
      .o_pc_we        (o_pc_we),
      .o_if_id_we     (o_if_id_we),
      .o_id_ex_bubble (o_id_ex_bubble),
      .o_fw_a_sel     (o_fw_a_sel),
      .o_fw_b_sel     (o_fw_b_sel)
   );

endmodule

/* hazard/hazard_combiner.sv */
`timescale 1ns/1ps

module hazard_combiner
   import hazard_pkg::*;
(
   input  logic      i_stall,        // from stall detector
   input  fw_match_t i_match,        // from forward selector
   output logic      o_pc_we,        // PC update enable
   output logic      o_if_id_we,     // IF/ID latch enable
   output logic      o_id_ex_bubble, // nop into ID/EX
   output fw_sel_t   o_fw_a_sel,     // rs operand mux
   output fw_sel_t   o_fw_b_sel      // rt operand mux
);

   // newest producer wins, EX/MEM over MEM/WB
   function automatic fw_sel_t resolve(input logic ex_mem, input logic mem_wb);
      if (ex_mem)
         resolve = FW_EX_MEM;
      else if (mem_wb)
         resolve = FW_MEM_WB;
      else
         resolve = FW_REGFILE;
   endfunction

   // stall freezes front end, ID/EX gets an empty slot
   assign o_pc_we        = ~i_stall;
   assign o_if_id_we     = ~i_stall;
   assign o_id_ex_bubble = i_stall;

   assign o_fw_a_sel = resolve(i_match.rs_ex_mem, i_match.rs_mem_wb);
   assign o_fw_b_sel = resolve(i_match.rt_ex_mem, i_match.rt_mem_wb);

endmodule

/* hazard/forward_selector.sv */
`timescale 1ns/1ps

module forward_selector
   import cpu_isa_pkg::*, hazard_pkg::*;
(
   input  pipe_state_t i_pipe,  // latch record, EX operands in id_ex
   output fw_match_t   o_match  // raw match bits
);

   reg_idx_t ex_rs;       // operands of the instruction now in EX
   reg_idx_t ex_rt;
   logic     exmem_prod;  // EX/MEM will write something useful
   logic     memwb_prod;  // MEM/WB will write something useful

   assign ex_rs = i_pipe.id_ex.rs;
   assign ex_rt = i_pipe.id_ex.rt;

   // producer qualifiers, r0 is hardwired so never forwarded
   assign exmem_prod = i_pipe.ex_mem.valid && i_pipe.ex_mem.wfr &&
                       (i_pipe.ex_mem.rd != '0);
   assign memwb_prod = i_pipe.mem_wb.valid && i_pipe.mem_wb.wfr &&
                       (i_pipe.mem_wb.rd != '0);

   // no priority here, the combiner decides
   always_comb begin
      o_match.rs_ex_mem = exmem_prod && (i_pipe.ex_mem.rd == ex_rs);
      o_match.rs_mem_wb = memwb_prod && (i_pipe.mem_wb.rd == ex_rs);
      o_match.rt_ex_mem = exmem_prod && (i_pipe.ex_mem.rd == ex_rt);
      o_match.rt_mem_wb = memwb_prod && (i_pipe.mem_wb.rd == ex_rt);
   end

endmodule

/* hazard/stall_detector.sv */
`timescale 1ns/1ps

module stall_detector
   import cpu_isa_pkg::*, hazard_pkg::*;
(
   input  logic        i_id_valid, // ID holds an instruction
   input  id_instr_t   i_id_instr, // operands and class flags
   input  pipe_state_t i_pipe,     // in-flight destinations
   output logic        o_stall     // hold PC and IF/ID
);

   // per-stage hit terms, r0 never counts
   logic idex_rs, idex_rt;
   logic exmem_rs, exmem_rt;
   logic memwb_rs, memwb_rt;
   logic any_rs, any_rt; // some stage still owes the operand

   function automatic logic hits(input stage_info_t s, input reg_idx_t r);
      hits = s.valid && s.wfr && (s.rd != '0) && (s.rd == r);
   endfunction

   assign idex_rs  = hits(i_pipe.id_ex,  i_id_instr.rs);
   assign idex_rt  = hits(i_pipe.id_ex,  i_id_instr.rt);
   assign exmem_rs = hits(i_pipe.ex_mem, i_id_instr.rs);
   assign exmem_rt = hits(i_pipe.ex_mem, i_id_instr.rt);
   assign memwb_rs = hits(i_pipe.mem_wb, i_id_instr.rs);
   assign memwb_rt = hits(i_pipe.mem_wb, i_id_instr.rt);

   assign any_rs = idex_rs | exmem_rs | memwb_rs;
   assign any_rt = idex_rt | exmem_rt | memwb_rt;

   // same order as the bubble unit: load, branch, jump
   always_comb begin
      if (!i_id_valid) begin
         o_stall = 1'b0; // nothing to protect
      end else if (i_pipe.id_ex.read_mem && (idex_rs || idex_rt)) begin
         o_stall = 1'b1; // load-use, data not ready until MEM
      end else if (i_id_instr.branch && (any_rs || any_rt)) begin
         o_stall = 1'b1; // branch compares in ID, needs both regs final
      end else if (i_id_instr.jump && any_rs) begin
         o_stall = 1'b1; // jr target, rs only
      end else begin
         o_stall = 1'b0;
      end
   end

endmodule

/* hazard/dest_tracker.sv */
`timescale 1ns/1ps

module dest_tracker
   import cpu_isa_pkg::*, hazard_pkg::*;
(
   input  logic        i_clk,
   input  logic        i_rst_n,     // sync, active low
   input  logic        i_id_valid,  // instruction present in ID
   input  id_instr_t   i_id_instr,  // decoded ID instruction
   input  logic        i_bubble,    // stall, ID/EX gets a nop
   output pipe_state_t o_pipe       // current latch record
);

   pipe_state_t pipe_q;     // ID/EX, EX/MEM, MEM/WB shadow
   stage_info_t id_ex_next; // record entering ID/EX

   // ID instruction reduced to what the latches carry
   always_comb begin
      id_ex_next.valid    = i_id_valid & ~i_bubble; // bubble -> invalid slot
      id_ex_next.rs       = i_id_instr.rs;
      id_ex_next.rt       = i_id_instr.rt;
      id_ex_next.rd       = i_id_instr.rd;
      id_ex_next.wfr      = i_id_instr.wfr;
      id_ex_next.read_mem = i_id_instr.read_mem;
   end

   // shift every cycle, older stages drain under stall
   always_ff @(posedge i_clk) begin
      if (!i_rst_n) begin
         pipe_q.id_ex.valid  <= 1'b0; // only valid bits cleared
         pipe_q.ex_mem.valid <= 1'b0;
         pipe_q.mem_wb.valid <= 1'b0;
      end else begin
         pipe_q.mem_wb <= pipe_q.ex_mem; // oldest takes middle
         pipe_q.ex_mem <= pipe_q.id_ex;
         pipe_q.id_ex  <= id_ex_next;    // new issue or bubble
      end
   end

   assign o_pipe = pipe_q;

endmodule

/* common/hazard_pkg.sv */
`include "hazard_settings.svh"

package hazard_pkg;

   import cpu_isa_pkg::*;

   // one pipeline latch as tracked by the hazard logic
   typedef struct packed {
      logic     valid;    // slot holds a real instruction
      reg_idx_t rs;
      reg_idx_t rt;
      reg_idx_t rd;       // destination register
      logic     wfr;      // will write rd
      logic     read_mem; // load, data only after MEM
   } stage_info_t;

   // shadow of the three latches behind ID
   typedef struct packed {
      stage_info_t id_ex;
      stage_info_t ex_mem;
      stage_info_t mem_wb;
   } pipe_state_t;

   // raw operand matches for the EX instruction, no priority yet
   typedef struct packed {
      logic rs_ex_mem; // rs produced by EX/MEM
      logic rs_mem_wb; // rs produced by MEM/WB
      logic rt_ex_mem; // rt produced by EX/MEM
      logic rt_mem_wb; // rt produced by MEM/WB
   } fw_match_t;

   // operand mux select in EX
   typedef logic [`NB_MUX_FW-1:0] fw_sel_t;

   localparam fw_sel_t FW_REGFILE = fw_sel_t'(0); // value read in ID
   localparam fw_sel_t FW_EX_MEM  = fw_sel_t'(1); // alu result one stage ahead
   localparam fw_sel_t FW_MEM_WB  = fw_sel_t'(2); // writeback data

endpackage

/* common/cpu_isa_pkg.sv */
`include "hazard_settings.svh"

package cpu_isa_pkg;

   // register index as seen by the isa
   typedef logic [`NB_REG-1:0] reg_idx_t;

   // decoded instruction sitting in ID
   typedef struct packed {
      reg_idx_t rs;       // first source operand
      reg_idx_t rt;       // second source operand
      reg_idx_t rd;       // destination
      logic     wfr;      // writes the register file
      logic     read_mem; // load
      logic     branch;   // taken-branch candidate, compares rs/rt in ID
      logic     jump;     // jump register, reads rs
   } id_instr_t;

endpackage

/* common/hazard_settings.svh */
`ifndef HAZARD_SETTINGS_SVH
`define HAZARD_SETTINGS_SVH

// architectural widths of the hazard subsystem

`define NB_REG    5 // register index, 32 gprs
`define NB_MUX_FW 2 // forward mux select, three sources used

`endif
